// File: common/memPkg.sv
// ------------------------------
// Widths shared by the Wishbone ports and the SRAM
// Byte lanes are 8 bits, so SelW is DataW / 8
// Word index is 16 bits, the SRAM uses only its low bits
// ------------------------------
package memPkg;

  parameter int unsigned BusAddrW = 32;  // Wishbone byte address
  parameter int unsigned DataW    = 32;
  parameter int unsigned SelW     = 4;   // Byte lanes per word
  parameter int unsigned IdxW     = 16;

  typedef logic [BusAddrW-1:0] busAddr_t;
  typedef logic [DataW-1:0]    data_t;
  typedef logic [SelW-1:0]     sel_t;
  typedef logic [IdxW-1:0]     wordIdx_t;

  // Master to slave, classic cycle only
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    busAddr_t adr;
    data_t    dat;
    sel_t     sel;
  } wbReq_t;

  // Slave to master
  typedef struct packed {
    logic  ack;
    logic  err;
    data_t dat;
  } wbRsp_t;

  // One SRAM access, valid while req is high
  typedef struct packed {
    logic     req;
    logic     we;
    wordIdx_t addr;
    data_t    wdata;
    sel_t     be;
  } sramReq_t;

  typedef enum logic [1:0] {
    Idle,
    Wait,  // Read latency countdown
    Resp
  } portState_e;

endpackage

// File: sram/shiftReg.sv
// ------------------------------
// Delay line for one data word
// Depth of zero is a plain wire, no register
// ------------------------------
module shiftReg #(
  parameter int unsigned Depth = 1
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  memPkg::data_t d_i,
  output memPkg::data_t d_o
);
  import memPkg::*;

  if (Depth == 0) begin : gen_pass
    assign d_o = d_i;
  end else begin : gen_chain
    data_t stages [Depth];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        for (int i = 0; i < Depth; i++) begin
          stages[i] <= '0;
        end
      end else begin
        stages[0] <= d_i;
        // Each stage takes the one before it
        for (int i = 1; i < Depth; i++) begin
          stages[i] <= stages[i-1];
        end
      end
    end

    assign d_o = stages[Depth-1];  // Oldest word
  end

endmodule

// File: sram/tcSram.sv
// ------------------------------
// Word array has no reset, the read registers do
// Latency must be at least 1, 8-bit byte lanes only
// Same-cycle writes to one word resolve by port order
// ------------------------------
module tcSram #(
  parameter int unsigned NumWords = 64,
  parameter int unsigned NumPorts = 2,
  parameter int unsigned Latency  = 1
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  memPkg::sramReq_t [NumPorts-1:0] req_i,
  output memPkg::data_t    [NumPorts-1:0] rdata_o
);
  import memPkg::*;

  localparam int unsigned AddrW = (NumWords > 1) ? $clog2(NumWords) : 1;
  localparam int unsigned LaneW = DataW / SelW;

  if (Latency < 1) begin : gen_latencyCheck
    $error("tcSram needs a Latency of at least 1");
  end

  data_t                mem [NumWords];
  data_t [NumPorts-1:0] rdata;  // First read stage, one per port

  // Later ports overwrite earlier ones within the same edge
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NumPorts; p++) begin
      if (req_i[p].req && req_i[p].we) begin
        for (int b = 0; b < SelW; b++) begin
          if (req_i[p].be[b]) begin
            mem[req_i[p].addr[AddrW-1:0]][b*LaneW +: LaneW] <=
              req_i[p].wdata[b*LaneW +: LaneW];
          end
        end
      end
    end
  end

  // Reads see the word from before this edge's writes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata <= '0;
    end else begin
      for (int p = 0; p < NumPorts; p++) begin
        if (req_i[p].req && !req_i[p].we) begin
          rdata[p] <= mem[req_i[p].addr[AddrW-1:0]];
        end
      end
    end
  end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    // Remaining Latency - 1 cycles
    shiftReg #(
      .Depth (Latency - 1)
    ) i_rdataDelay (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .d_i    (rdata[p]),
      .d_o    (rdata_o[p])
    );

    // Adapter window must fit the array
    a_addrInRange: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      req_i[p].req |-> (32'(req_i[p].addr) < NumWords)
    ) else $error("tcSram port %0d address %0d beyond %0d words",
                  p, req_i[p].addr, NumWords);
  end

endmodule

// File: hdl/wbSramPort.sv
// ------------------------------
// Wishbone classic slave for single cycles
// Master holds the request until ack or err
// Read ack comes Latency cycles after acceptance
// ------------------------------
module wbSramPort #(
  parameter memPkg::busAddr_t BaseAddr = 32'h0000_1000,
  parameter int unsigned      NumWords = 64,
  parameter int unsigned      Latency  = 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  memPkg::wbReq_t   wb_i,
  output memPkg::wbRsp_t   wb_o,
  output memPkg::sramReq_t sram_o,
  input  memPkg::data_t    rdata_i
);
  import memPkg::*;

  localparam busAddr_t    WinSize    = busAddr_t'(NumWords * SelW);
  localparam int unsigned LowBits    = $clog2(SelW);
  localparam int unsigned WaitCycles = (Latency > 1) ? Latency - 2 : 0;
  localparam int unsigned CntW       = (WaitCycles > 0) ? $clog2(WaitCycles + 1) : 1;

  portState_e      state;
  portState_e      stateNext;
  logic [CntW-1:0] cnt;     // Wait cycles left
  logic            isErr;   // Pending response is err
  busAddr_t        offset;
  logic            inWin;
  logic            accept;

  assign offset = wb_i.adr - BaseAddr;
  assign inWin  = (wb_i.adr >= BaseAddr) && (offset < WinSize);
  assign accept = (state == Idle) && wb_i.cyc && wb_i.stb;

  // One request pulse in the accepting cycle
  assign sram_o.req   = accept && inWin;
  assign sram_o.we    = wb_i.we;
  assign sram_o.addr  = offset[LowBits +: IdxW];  // Byte offset to word index
  assign sram_o.wdata = wb_i.dat;
  assign sram_o.be    = wb_i.sel;

  always_comb begin
    stateNext = state;
    unique case (state)
      Idle: begin
        if (accept) begin
          // Only reads longer than one cycle need the countdown
          if (inWin && !wb_i.we && (Latency > 1)) begin
            stateNext = Wait;
          end else begin
            stateNext = Resp;
          end
        end
      end
      Wait: begin
        if (cnt == '0) begin
          stateNext = Resp;
        end
      end
      Resp:    stateNext = Idle;
      default: stateNext = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state <= Idle;
      cnt   <= '0;
      isErr <= 1'b0;
    end else begin
      state <= stateNext;
      if (accept) begin
        isErr <= !inWin;
        cnt   <= CntW'(WaitCycles);
      end else if (state == Wait) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  assign wb_o.ack = (state == Resp) && !isErr;
  assign wb_o.err = (state == Resp) && isErr;
  assign wb_o.dat = rdata_i;  // SRAM output is already aligned to ack

  a_stbHeld: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (wb_i.cyc && wb_i.stb && !wb_o.ack && !wb_o.err) |=> wb_i.stb
  ) else $error("wbSramPort stb dropped before ack or err");

  // Every request field stays put until the response
  a_reqStable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (wb_i.cyc && wb_i.stb && !wb_o.ack && !wb_o.err) |=> $stable(wb_i)
  ) else $error("wbSramPort request changed before ack or err");

endmodule

// File: hdl/memSubsys.sv
// ------------------------------
// Two Wishbone windows onto one shared word array
// Both windows alias the same storage
// Port 1 wins on same-cycle writes to one word
// ------------------------------
module memSubsys #(
  parameter memPkg::busAddr_t BaseAddr0 = 32'h0000_1000,
  parameter memPkg::busAddr_t BaseAddr1 = 32'h0000_2000,
  parameter int unsigned      NumWords  = 64,
  parameter int unsigned      Latency   = 2
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  memPkg::wbReq_t wb0_i,
  output memPkg::wbRsp_t wb0_o,
  input  memPkg::wbReq_t wb1_i,
  output memPkg::wbRsp_t wb1_o
);
  import memPkg::*;

  sramReq_t [1:0] sramReq;    // Index is the SRAM port
  data_t    [1:0] sramRdata;

  wbSramPort #(
    .BaseAddr (BaseAddr0),
    .NumWords (NumWords),
    .Latency  (Latency)
  ) i_port0 (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wb_i    (wb0_i),
    .wb_o    (wb0_o),
    .sram_o  (sramReq[0]),
    .rdata_i (sramRdata[0])
  );

  wbSramPort #(
    .BaseAddr (BaseAddr1),
    .NumWords (NumWords),
    .Latency  (Latency)
  ) i_port1 (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wb_i    (wb1_i),
    .wb_o    (wb1_o),
    .sram_o  (sramReq[1]),
    .rdata_i (sramRdata[1])
  );

  tcSram #(
    .NumWords (NumWords),
    .NumPorts (2),
    .Latency  (Latency)
  ) i_sram (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (sramReq),
    .rdata_o (sramRdata)
  );

endmodule

// File: tb/tbClock.sv
// ------------------------------
// Free-running clock from time zero
// Reset is released 10 units after the last reset edge
// ------------------------------
module tbClock #(
  parameter int unsigned Period      = 100,
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #10 rst_no = 1'b1;  // Clear of the edge
  end

endmodule

// File: tb/memChecker.sv
// ------------------------------
// Reference model of the shared word array
// Reads compare only bytes that were written before
// Samples ports at the rising edge, pre-edge values
// ------------------------------
module memChecker #(
  parameter memPkg::busAddr_t BaseAddr0 = 32'h0000_1000,
  parameter memPkg::busAddr_t BaseAddr1 = 32'h0000_2000,
  parameter int unsigned      NumWords  = 64,
  parameter int unsigned      Latency   = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  memPkg::wbReq_t [1:0] wbReq_i,
  input  memPkg::wbRsp_t [1:0] wbRsp_i,
  output int unsigned          dataErrs_o,
  output int unsigned          protoErrs_o,
  output int unsigned          txns_o
);
  import memPkg::*;

  data_t    model [NumWords];
  sel_t     known [NumWords];  // Bytes written at least once
  logic     busy [2];
  logic     expErr [2];
  logic     wrPend [2];        // Write to commit at this edge
  data_t    expDat [2];        // Word as it was at acceptance
  data_t    expMask [2];
  int       idx [2];
  longint   due [2];           // Edge that samples the response
  longint   cycle;
  busAddr_t base;
  busAddr_t offset;

  function automatic data_t laneMask(sel_t sel);
    data_t m;
    for (int b = 0; b < SelW; b++) begin
      m[b*8 +: 8] = {8{sel[b]}};
    end
    return m;
  endfunction

  task automatic reportMismatch(input string name, input data_t expVal, input data_t actVal);
    $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, expVal, actVal);
    dataErrs_o++;
  endtask

  task automatic reportFault(input string what);
    $display("error at %0t: %s", $time, what);
    protoErrs_o++;
  endtask

  task automatic acceptRequest(input int p);
    base       = (p == 0) ? BaseAddr0 : BaseAddr1;
    offset     = wbReq_i[p].adr - base;
    busy[p]    = 1'b1;
    expErr[p]  = !(wbReq_i[p].adr >= base && offset < busAddr_t'(NumWords * 4));
    idx[p]     = int'(offset >> 2);  // Low two bits ignored
    expMask[p] = '0;
    due[p]     = cycle + 1;
    txns_o++;
    if (!expErr[p] && wbReq_i[p].we) begin
      wrPend[p] = 1'b1;
    end else if (!expErr[p]) begin
      expDat[p]  = model[idx[p]];
      expMask[p] = laneMask(known[idx[p]]);
      due[p]     = cycle + Latency;
    end
  endtask

  task automatic checkResponse(input int p);
    string name;
    name = $sformatf("wb%0d_o", p);
    if (wbRsp_i[p].ack !== !expErr[p]) begin
      reportMismatch({name, ".ack"}, data_t'(!expErr[p]), data_t'(wbRsp_i[p].ack));
    end
    if (wbRsp_i[p].err !== expErr[p]) begin
      reportMismatch({name, ".err"}, data_t'(expErr[p]), data_t'(wbRsp_i[p].err));
    end
    if ((wbRsp_i[p].dat & expMask[p]) !== (expDat[p] & expMask[p])) begin
      reportMismatch({name, ".dat"}, expDat[p], wbRsp_i[p].dat);
    end
  endtask

  initial begin
    dataErrs_o  = 0;
    protoErrs_o = 0;
    txns_o      = 0;
    for (int i = 0; i < NumWords; i++) begin
      model[i] = '0;
      known[i] = '0;
    end
  end

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      cycle = 0;
      for (int p = 0; p < 2; p++) begin
        busy[p] = 1'b0;
        if (wbRsp_i[p].ack || wbRsp_i[p].err) begin
          reportFault($sformatf("port %0d responds during reset", p));
        end
      end
    end else begin
      cycle++;
      for (int p = 0; p < 2; p++) begin
        wrPend[p] = 1'b0;
        if (busy[p] && cycle == due[p]) begin
          checkResponse(p);
          busy[p] = 1'b0;
        end else if (wbRsp_i[p].ack || wbRsp_i[p].err) begin
          reportFault($sformatf("port %0d ack or err outside its one-cycle slot", p));
        end else if (!busy[p] && wbReq_i[p].cyc && wbReq_i[p].stb) begin
          acceptRequest(p);
        end
      end
      // Port 1 goes last and wins shared bytes
      for (int p = 0; p < 2; p++) begin
        if (wrPend[p]) begin
          for (int b = 0; b < SelW; b++) begin
            if (wbReq_i[p].sel[b]) begin
              model[idx[p]][b*8 +: 8] = wbReq_i[p].dat[b*8 +: 8];
              known[idx[p]][b]        = 1'b1;
            end
          end
        end
      end
    end
  end

endmodule

// File: tb/tbMemSubsys.sv
// ------------------------------
// Random single cycles on both ports at once
// Half the in-window accesses hit four words
// so that same-cycle collisions occur
// ------------------------------
module tbMemSubsys;
  import memPkg::*;

  localparam busAddr_t    BaseAddr0 = 32'h0000_1000;
  localparam busAddr_t    BaseAddr1 = 32'h0000_2000;
  localparam int unsigned NumWords  = 64;
  localparam int unsigned Latency   = 2;
  localparam int unsigned NumTxns   = 300;  // Per port
  localparam int unsigned Period    = 100;
  localparam int          Seed      = 32'h6f9bfcec;

  logic         clk;
  logic         rstN;
  wbReq_t [1:0] wbReq;
  wbRsp_t [1:0] wbRsp;
  int unsigned  dataErrs;
  int unsigned  protoErrs;
  int unsigned  txns;

  tbClock #(
    .Period      (Period),
    .ResetCycles (3)
  ) i_clock (
    .clk_o  (clk),
    .rst_no (rstN)
  );

  memSubsys #(
    .BaseAddr0 (BaseAddr0),
    .BaseAddr1 (BaseAddr1),
    .NumWords  (NumWords),
    .Latency   (Latency)
  ) i_memSubsys (
    .clk_i  (clk),
    .rst_ni (rstN),
    .wb0_i  (wbReq[0]),
    .wb0_o  (wbRsp[0]),
    .wb1_i  (wbReq[1]),
    .wb1_o  (wbRsp[1])
  );

  memChecker #(
    .BaseAddr0 (BaseAddr0),
    .BaseAddr1 (BaseAddr1),
    .NumWords  (NumWords),
    .Latency   (Latency)
  ) i_checker (
    .clk_i       (clk),
    .rst_ni      (rstN),
    .wbReq_i     (wbReq),
    .wbRsp_i     (wbRsp),
    .dataErrs_o  (dataErrs),
    .protoErrs_o (protoErrs),
    .txns_o      (txns)
  );

  task automatic runPort(input int p);
    int          seed;
    logic [31:0] r;
    logic [5:0]  word;
    busAddr_t    base;
    wbReq_t      req;
    seed = Seed + p;  // One stream per port
    base = (p == 0) ? BaseAddr0 : BaseAddr1;
    wait (rstN);
    @(posedge clk);
    for (int t = 0; t < NumTxns; t++) begin
      r    = $random(seed);
      word = r[3] ? r[9:4] : {4'b0, r[5:4]};
      if (r[2:0] == 3'd0) begin
        // Just below or just above the window
        req.adr = r[11] ? base - busAddr_t'({r[19:12], 2'b00}) - 32'd4
                        : base + busAddr_t'(NumWords * 4) + busAddr_t'(r[19:12]);
      end else begin
        req.adr = base + busAddr_t'({word, r[13:12]});  // Random low bits
      end
      r       = $random(seed);
      req.cyc = 1'b1;
      req.stb = 1'b1;
      req.we  = r[0];
      req.sel = r[7:4];
      req.dat = $random(seed);
      #10;
      wbReq[p] = req;
      @(posedge clk);
      while (!(wbRsp[p].ack || wbRsp[p].err)) begin
        @(posedge clk);
      end
      #10;
      wbReq[p] = '0;
      @(posedge clk);  // Idle edge with stb low
    end
  endtask

  initial begin
    wbReq = '0;
    fork
      runPort(0);
      runPort(1);
    join
    repeat (2) @(posedge clk);
    if (txns != 2 * NumTxns) begin
      $display("accepted %0d transactions but %0d were issued", txns, 2 * NumTxns);
    end
    $display("errors: %0d data, %0d protocol", dataErrs, protoErrs);
    if (dataErrs == 0 && protoErrs == 0 && txns == 2 * NumTxns) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Ten cycles per transaction, far above the slowest read
  initial begin
    #(2 * NumTxns * 10 * Period);
    $display("timeout: transactions still open after %0d cycles", 2 * NumTxns * 10);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: src.f
common/memPkg.sv
sram/shiftReg.sv
sram/tcSram.sv
hdl/wbSramPort.sv
hdl/memSubsys.sv
tb/tbClock.sv
tb/memChecker.sv
tb/tbMemSubsys.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, result decided from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f src.f --top-module tbMemSubsys -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VtbMemSubsys > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
  exit 0
fi
exit 1
